// File: logic/int_ctrl_pkg.sv
// Shared constants, vector types and controller state for the interrupt grant controller.
// Imported by every RTL block and by the testbench.
`default_nettype none

package int_ctrl_pkg;

    // eight level-sensitive request lines
    localparam int NUM_SRC = 8;

    // width of a source number
    localparam int SRC_IDX_W = 3;

    // hold counter width, caps HOLD_LIMIT at 255
    localparam int TIMER_W = 8;

    // one bit per source: requests, stuck mask, eligible set
    typedef logic [NUM_SRC-1:0] src_vec_t;

    // source number
    typedef logic [SRC_IDX_W-1:0] src_idx_t;

    // cycles the current grant has been held
    typedef logic [TIMER_W-1:0] hold_cnt_t;

    // grant FSM
    typedef enum logic [0:0] {
        // no grant held
        ST_IDLE    = 1'b0,
        // a source owns the grant
        ST_GRANTED = 1'b1
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: logic/priority_encoder.sv
// Combinational search for the lowest set bit of the eligible-request vector.
// Bit 0 has the highest priority.
`timescale 1ns/1ps
`default_nettype none

module priority_encoder (
    input  int_ctrl_pkg::src_vec_t eligible,
    output logic                   any_eligible,
    output int_ctrl_pkg::src_idx_t first_idx
);

    import int_ctrl_pkg::*;

    // anything to grant at all
    assign any_eligible = |eligible;

    // walk from the top down so the lowest set bit is the last one written
    always_comb begin
        first_idx = '0;
        for (int i = NUM_SRC - 1; i >= 0; i--) begin
            if (eligible[i]) begin
                first_idx = src_idx_t'(i);
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/hold_timer.sv
// Counts the cycles the current grant has been held and flags when the limit is reached.
// The grant controller restarts it whenever the grant is released or replaced.
`timescale 1ns/1ps
`default_nettype none

module hold_timer #(
    parameter int_ctrl_pkg::hold_cnt_t HOLD_LIMIT = 8'd255
) (
    input  logic clk,
    input  logic arst_n,
    input  logic restart,
    output logic expired
);

    import int_ctrl_pkg::*;

    hold_cnt_t cnt;
    logic      at_limit;

    // compare on registered count only
    assign at_limit = (cnt == HOLD_LIMIT);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else if (restart) begin
            cnt <= '0;
        end else if (!at_limit) begin
            cnt <= cnt + 1'b1;
        end
        // stays at the limit if the controller ever fails to act on expiry
    end

    assign expired = at_limit;

endmodule

`default_nettype wire

// File: logic/grant_controller.sv
// Grant FSM with stuck-source mask and registered timeout pulse.
// Forms the eligible set for the encoder and restarts the hold timer on every handover.
`timescale 1ns/1ps
`default_nettype none

module grant_controller (
    input  logic                   clk,
    input  logic                   arst_n,
    input  int_ctrl_pkg::src_vec_t req,
    input  logic                   any_eligible,
    input  int_ctrl_pkg::src_idx_t first_idx,
    input  logic                   expired,
    output int_ctrl_pkg::src_vec_t eligible,
    output logic                   restart,
    output logic                   grant_valid,
    output int_ctrl_pkg::src_idx_t grant_idx,
    output logic                   timeout,
    output int_ctrl_pkg::src_vec_t masked
);

    import int_ctrl_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    src_idx_t    idx_q;
    src_idx_t    idx_d;
    src_vec_t    mask_q;
    src_vec_t    mask_d;
    logic        timeout_q;

    logic        granted;
    logic        grant_req;
    logic        expiry;
    logic        keep;
    src_vec_t    grant_bit;

    assign granted   = (state_q == ST_GRANTED);
    assign grant_req = req[idx_q];

    // current owner ran out of hold time while still requesting
    assign expiry = granted & grant_req & expired;

    // owner still requesting and within its limit
    assign keep = granted & grant_req & ~expired;

    assign grant_bit = src_vec_t'(1) << idx_q;

    // mask bits only survive while their request stays high
    always_comb begin
        mask_d = mask_q & req;
        if (expiry) begin
            mask_d = mask_d | grant_bit;
        end
    end

    // eligibility is judged against the mask as it will be after this edge,
    // so a source timed out now cannot win straight back
    assign eligible = req & ~mask_d;

    // grant FSM
    always_comb begin
        state_d = state_q;
        idx_d   = idx_q;
        case (state_q)
            ST_IDLE: begin
                if (any_eligible) begin
                    state_d = ST_GRANTED;
                end
                // first_idx is 0 with nothing eligible
                idx_d = first_idx;
            end
            ST_GRANTED: begin
                if (!keep) begin
                    // release or hand over to the next lowest eligible source
                    state_d = any_eligible ? ST_GRANTED : ST_IDLE;
                    idx_d   = first_idx;
                end
            end
            default: begin
                state_d = ST_IDLE;
                idx_d   = '0;
            end
        endcase
    end

    // counter runs only while the same grant is kept
    assign restart = ~keep;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= ST_IDLE;
            idx_q   <= '0;
        end else begin
            state_q <= state_d;
            idx_q   <= idx_d;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mask_q <= '0;
        end else begin
            mask_q <= mask_d;
        end
    end

    // one-cycle pulse after the edge that saw the expiry
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            timeout_q <= 1'b0;
        end else begin
            timeout_q <= expiry;
        end
    end

    assign grant_valid = granted;
    assign grant_idx   = idx_q;
    assign timeout     = timeout_q;
    assign masked      = mask_q;

endmodule

`default_nettype wire

// File: logic/int_ctrl_top.sv
// Top level of the eight-source interrupt grant controller.
// Set HOLD_LIMIT here to bound how long one source may keep the grant.
`timescale 1ns/1ps
`default_nettype none

module int_ctrl_top #(
    parameter int_ctrl_pkg::hold_cnt_t HOLD_LIMIT = 8'd255
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  int_ctrl_pkg::src_vec_t req,
    output logic                   grant_valid,
    output int_ctrl_pkg::src_idx_t grant_idx,
    output logic                   timeout,
    output int_ctrl_pkg::src_vec_t masked
);

    import int_ctrl_pkg::*;

    // controller to encoder
    src_vec_t eligible;

    // encoder back to controller
    logic     any_eligible;
    src_idx_t first_idx;

    // controller and timer handshake of plain levels
    logic     restart;
    logic     expired;

    priority_encoder u_priority_encoder (
        .eligible     (eligible),
        .any_eligible (any_eligible),
        .first_idx    (first_idx)
    );

    hold_timer #(
        .HOLD_LIMIT (HOLD_LIMIT)
    ) u_hold_timer (
        .clk     (clk),
        .arst_n  (arst_n),
        .restart (restart),
        .expired (expired)
    );

    grant_controller u_grant_controller (
        .clk          (clk),
        .arst_n       (arst_n),
        .req          (req),
        .any_eligible (any_eligible),
        .first_idx    (first_idx),
        .expired      (expired),
        .eligible     (eligible),
        .restart      (restart),
        .grant_valid  (grant_valid),
        .grant_idx    (grant_idx),
        .timeout      (timeout),
        .masked       (masked)
    );

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
// Free-running testbench clock.
// PERIOD_NS sets the full period, the clock starts low.
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// File: tests/int_ctrl_tb.sv
// Random-stimulus testbench for the interrupt grant controller.
// A cycle model of the grant rules runs beside the DUT and is compared at every falling edge.
`timescale 1ns/1ps
`default_nettype none

module int_ctrl_tb;

    import int_ctrl_pkg::*;

    localparam hold_cnt_t   HOLD_LIMIT   = 8'd12;
    localparam int          RESET_CYCLES = 2;
    localparam int          PHASE_CYCLES = 1000;
    localparam int          NUM_PHASES   = 3;
    // one spare phase worth of cycles on top of the real run
    localparam int          CYCLE_LIMIT  = (NUM_PHASES + 1) * PHASE_CYCLES;
    localparam logic [31:0] LFSR_SEED    = 32'hf91065c9;
    localparam logic [31:0] LFSR_TAPS    = 32'h80200003;

    logic     clk;
    logic     arst_n;
    src_vec_t req;
    logic     grant_valid;
    src_idx_t grant_idx;
    logic     timeout;
    src_vec_t masked;

    // expected state from the model
    logic      exp_valid;
    src_idx_t  exp_idx;
    logic      idx_defined;
    src_vec_t  exp_mask;
    logic      exp_timeout;
    hold_cnt_t exp_cnt;

    logic [31:0] lfsr;
    int          bit_errors;
    int          idx_errors;
    int          vec_errors;
    int          other_errors;
    int          timeouts_seen;
    int          mask_hits;
    int          cycles = 0;

    tb_clock_gen #(
        .PERIOD_NS (100)
    ) u_clock_gen (
        .clk (clk)
    );

    int_ctrl_top #(
        .HOLD_LIMIT (HOLD_LIMIT)
    ) DUT (
        .clk         (clk),
        .arst_n      (arst_n),
        .req         (req),
        .grant_valid (grant_valid),
        .grant_idx   (grant_idx),
        .timeout     (timeout),
        .masked      (masked)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ LFSR_TAPS;
        end
        return n;
    endfunction

    // one LFSR step per bit taken
    task automatic random_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    task automatic model_reset();
        exp_valid   = 1'b0;
        exp_idx     = '0;
        idx_defined = 1'b1;
        exp_mask    = '0;
        exp_timeout = 1'b0;
        exp_cnt     = '0;
    endtask

    task automatic model_edge(input src_vec_t r);
        logic     was_valid;
        logic     held;
        logic     expiry;
        src_vec_t next_mask;
        src_vec_t cand;
        int       pick;
        was_valid = exp_valid;
        held      = exp_valid && r[exp_idx];
        expiry    = held && (exp_cnt == HOLD_LIMIT);
        next_mask = exp_mask & r;
        if (expiry) begin
            next_mask[exp_idx] = 1'b1;
        end
        exp_timeout = expiry;
        if (held && !expiry) begin
            exp_cnt = exp_cnt + 8'd1;
        end else begin
            exp_cnt = '0;
            cand    = r & ~next_mask;
            pick    = -1;
            for (int i = 0; i < NUM_SRC; i++) begin
                if (cand[i] && pick < 0) begin
                    pick = i;
                end
            end
            exp_valid = (pick >= 0);
            if (pick >= 0) begin
                exp_idx = src_idx_t'(pick);
            end
        end
        // idle index is only known before the first grant
        idx_defined = exp_valid || (idx_defined && !was_valid);
        exp_mask    = next_mask;
    endtask

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            model_reset();
        end else begin
            model_edge(req);
        end
    end

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            bit_errors++;
            $display("** Error at %0t ns: %s expected %0b got %0b", $time, name, expected,
                     actual);
        end
    endtask

    task automatic check_idx(input string name, input src_idx_t expected,
                             input src_idx_t actual);
        if (actual !== expected) begin
            idx_errors++;
            $display("** Error at %0t ns: %s expected %0d got %0d", $time, name, expected,
                     actual);
        end
    endtask

    task automatic check_vec(input string name, input src_vec_t expected,
                             input src_vec_t actual);
        if (actual !== expected) begin
            vec_errors++;
            $display("** Error at %0t ns: %s expected %b got %b", $time, name, expected,
                     actual);
        end
    endtask

    task automatic check_outputs();
        check_bit("grant_valid", exp_valid, grant_valid);
        check_bit("timeout", exp_timeout, timeout);
        if (idx_defined) begin
            check_idx("grant_idx", exp_idx, grant_idx);
        end
        check_vec("masked", exp_mask, masked);
        if (grant_valid === 1'b1 && masked[grant_idx] === 1'b1) begin
            other_errors++;
            $display("grant held by source %0d while that source is masked", grant_idx);
        end
        if (timeout === 1'b1) begin
            timeouts_seen++;
        end
        if ((masked & req) != '0) begin
            mask_hits++;
        end
    endtask

    // 0 fast random, 1 sparse long holds, 2 mostly stuck
    task automatic next_req(input int phase);
        logic [31:0] r;
        src_vec_t    nxt;
        nxt = req;
        if (phase == 0) begin
            random_bits(NUM_SRC, r);
            nxt = r[NUM_SRC-1:0];
        end else begin
            for (int i = 0; i < NUM_SRC; i++) begin
                if (phase == 1 && nxt[i]) begin
                    random_bits(5, r);
                    if (r[4:0] == 5'd0) begin
                        nxt[i] = 1'b0;
                    end
                end else if (phase == 1) begin
                    random_bits(6, r);
                    if (r[5:0] == 6'd0) begin
                        nxt[i] = 1'b1;
                    end
                end else if (nxt[i]) begin
                    random_bits(6, r);
                    if (r[5:0] == 6'd0) begin
                        nxt[i] = 1'b0;
                    end
                end else begin
                    random_bits(1, r);
                    nxt[i] = r[0];
                end
            end
        end
        req = nxt;
    endtask

    // hang guard
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        int total;
        arst_n        = 1'b0;
        req           = '0;
        lfsr          = LFSR_SEED;
        bit_errors    = 0;
        idx_errors    = 0;
        vec_errors    = 0;
        other_errors  = 0;
        timeouts_seen = 0;
        mask_hits     = 0;

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_outputs();
        end
        arst_n = 1'b1;

        // one quiet cycle so the reset values are seen after release too
        @(negedge clk);
        check_outputs();

        for (int phase = 0; phase < NUM_PHASES; phase++) begin
            for (int c = 0; c < PHASE_CYCLES; c++) begin
                next_req(phase);
                @(negedge clk);
                check_outputs();
            end
        end

        if (timeouts_seen == 0) begin
            other_errors++;
            $display("no timeout pulse was seen during the run");
        end
        if (mask_hits == 0) begin
            other_errors++;
            $display("no source stayed masked while still requesting");
        end

        total = bit_errors + idx_errors + vec_errors + other_errors;
        $display("errors: grant_valid/timeout %0d, grant_idx %0d, masked %0d, other %0d",
                 bit_errors, idx_errors, vec_errors, other_errors);
        if (total == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: int_ctrl.f
logic/int_ctrl_pkg.sv
logic/priority_encoder.sv
logic/hold_timer.sv
logic/grant_controller.sv
logic/int_ctrl_top.sv
tests/tb_clock_gen.sv
tests/int_ctrl_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing
TOP      := int_ctrl_tb
FILELIST := int_ctrl.f

OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := All checks passed
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the result, the exit status of the binary is not used
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
